/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module spi_master_tb -Mdir obj_dir
	./obj_dir/Vspi_master_tb

clean:
	rm -rf obj_dir

/* dv/spi_master_tb.sv */
module spi_master_tb;

  localparam int SCLK_DIV       = 2;
  localparam int NUM_CMDS       = 32;
  localparam int FRAME_LATENCY  = 24 * SCLK_DIV + 1;  // Accept edge to cs_n seen high
  localparam int TIMEOUT_CYCLES = NUM_CMDS * (24 * SCLK_DIV + 10) + 50;

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso = 1'b0;
  logic        read_vld;
  logic [7:0]  read_data;

  // Command in bits 19:8 and expected read byte in 7:0
  logic [19:0] test_mem [0:NUM_CMDS-1];

  // Slave model state
  logic [7:0]  slave_regs [0:7];
  logic [11:0] slave_shift;
  logic [11:0] slave_word;
  logic [7:0]  slave_out;
  logic        slave_read;
  logic        slave_sclk_q;
  int          slave_count;

  // Monitor state
  logic [11:0] frame_cmd;
  logic [7:0]  exp_byte;
  logic        in_frame = 1'b0;
  logic        rdy_due = 1'b0;
  logic        sclk_seen = 1'b0;
  int          frame_cycles;
  int          frame_rises;
  int          accepted = 0;
  int          frames_done = 0;
  int          cycle_count = 0;

  spi_master #(
    .SCLK_DIV(SCLK_DIV)
  ) u_spi_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .read_vld (read_vld),
    .read_data(read_data)
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      stop_with_error("Timeout: the commands did not complete within the cycle limit");
    end
  end

  // Mode 0 SPI slave seen through clk samples of sclk
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < 8; k++)
      begin
        slave_regs[k] = '0;
      end
      slave_count = 0;
      slave_read  = 1'b0;
      miso <= 1'b0;
    end
    else if (cs_n)
    begin
      slave_count = 0;
      slave_read  = 1'b0;
      miso <= 1'b0;
    end
    else if (sclk && !slave_sclk_q)
    begin
      slave_shift = {slave_shift[10:0], mosi};
      slave_count = slave_count + 1;
      if (slave_count == 4 && !slave_shift[3])
      begin
        slave_read = 1'b1;
        slave_out  = slave_regs[slave_shift[2:0]];
      end
      if (slave_count == 12)
      begin
        slave_word = slave_shift;
        if (slave_shift[11])
        begin
          slave_regs[slave_shift[10:8]] = slave_shift[7:0];
        end
      end
    end
    else if (!sclk && slave_sclk_q && slave_read && slave_count >= 4 && slave_count < 12)
    begin
      miso <= slave_out[7];  // MSB first
      slave_out = {slave_out[6:0], 1'b0};
    end
    slave_sclk_q = sclk;
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (in_frame)
      begin
        frame_cycles = frame_cycles + 1;
        if (sclk && !sclk_seen && !cs_n)
        begin
          frame_rises = frame_rises + 1;
        end
        if (cs_n)
        begin
          check_value("frame latency", 32'(frame_cycles), 32'(FRAME_LATENCY));
          check_value("sclk rising edges", 32'(frame_rises), 32'd12);
          check_value("sclk", 32'(sclk), 32'd0);
          check_value("mosi word", 32'(slave_word), 32'(frame_cmd));
          check_value("read_vld", 32'(read_vld), 32'(!frame_cmd[11]));
          if (!frame_cmd[11])
          begin
            check_value("read_data", 32'(read_data), 32'(exp_byte));
          end
          frames_done = frames_done + 1;
          in_frame    = 1'b0;
          rdy_due     = 1'b1;
        end
        else
        begin
          check_value("read_vld", 32'(read_vld), 32'd0);
        end
      end
      else
      begin
        if (rdy_due)
        begin
          check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);  // Back in IDLE after DONE
          rdy_due = 1'b0;
        end
        check_value("read_vld", 32'(read_vld), 32'd0);
      end
      if (cmd_vld && cmd_rdy)
      begin
        if (accepted >= NUM_CMDS)
        begin
          stop_with_error("The DUT accepted more commands than the data file holds");
        end
        else
        begin
          check_value("cmd_in", 32'(cmd_in), 32'(test_mem[accepted][19:8]));
          frame_cmd    = cmd_in;
          exp_byte     = test_mem[accepted][7:0];
          accepted     = accepted + 1;
          in_frame     = 1'b1;
          frame_cycles = 0;
          frame_rises  = 0;
        end
      end
      sclk_seen = sclk;
    end
  end

  initial
  begin
    int gap;
    int hold;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    void'($urandom(32'ha395));
    $readmemh("dv/spi_testdata.txt", test_mem);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    check_value("cs_n", 32'(cs_n), 32'd1);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("mosi", 32'(mosi), 32'd0);
    check_value("read_vld", 32'(read_vld), 32'd0);
    for (int i = 0; i < NUM_CMDS; i++)
    begin
      gap  = $urandom % 6;
      hold = $urandom % 2;
      if (gap > 0)
      begin
        cmd_vld <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      // Wait for IDLE first when cmd_vld is not held
      if (hold == 0)
      begin
        cmd_vld <= 1'b0;
        @(posedge clk);
        while (!cmd_rdy)
        begin
          @(posedge clk);
        end
      end
      cmd_in  <= test_mem[i][19:8];
      cmd_vld <= 1'b1;
      @(posedge clk);
      while (!cmd_rdy)
      begin
        @(posedge clk);
      end
    end
    cmd_vld <= 1'b0;
    while (frames_done < NUM_CMDS)
    begin
      @(negedge clk);
    end
    repeat (3) @(posedge clk);
    check_value("cs_n", 32'(cs_n), 32'd1);  // No frame without a command
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* dv/spi_testdata.txt */
// Each entry: 3 hex digits of command, then 2 hex digits of expected read byte
// Command bit 11 set is a write (addr 10:8, data 7:0); expected byte is 00 for writes
00000
83c00
9a500
0003c
1ffa5
f8100
70081
5aa00
aff00
b0000
255ff
30000
c6900
8c300
000c3
4f069
d1200
ee700
6e7e7
50012
100a5
95a00
1c35a
f7e00
7ff7e
a0100
20001
3a500
b8000
30080
0ffc3
40069

/* project.f */
source/spi_pkg.sv
source/spi_sclk_gen.sv
source/spi_tx_shift.sv
source/spi_rx_shift.sv
source/spi_ctrl.sv
source/spi_master.sv
dv/spi_master_tb.sv

/* source/spi_ctrl.sv */
module spi_ctrl
  import spi_pkg::*;
#(
  parameter int SCLK_DIV = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  accept,
  output logic                  frame_active,
  input  logic                  sclk_fall,
  input  logic                  bit_count_done,
  input  logic [READ_WIDTH-1:0] rx_byte,
  input  logic                  cmd_is_write,
  output logic                  cs_n,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  // Accepting edge to cs_n rising
  localparam int FRAME_LATENCY = 2 * FRAME_BITS * SCLK_DIV + 1;

  spi_state_t state;
  logic       last_seen;  // 12th bit already sampled
  logic       frame_end;

  assign cmd_rdy      = (state == IDLE);
  assign accept       = cmd_vld && cmd_rdy;
  assign frame_active = (state == ACTIVE);

  // Falling edge that closes the 12th SCLK period
  assign frame_end = frame_active && last_seen && sclk_fall;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      last_seen <= 1'b0;
      cs_n      <= 1'b1;
      read_vld  <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            state     <= ACTIVE;
            last_seen <= 1'b0;
            cs_n      <= 1'b0;
          end
        end
        ACTIVE:
        begin
          if (bit_count_done)
          begin
            last_seen <= 1'b1;
          end
          if (frame_end)
          begin
            state    <= DONE;
            cs_n     <= 1'b1;
            read_vld <= !cmd_is_write;  // Pulses in DONE
          end
        end
        DONE:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Result byte, valid alongside read_vld
  always_ff @(posedge clk)
  begin
    if (frame_end && !cmd_is_write)
    begin
      read_data <= rx_byte;
    end
  end

  a_cs_low_active : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == ACTIVE) |-> !cs_n
  );

  // Command kind comes from the transmit shifter
  a_no_read_after_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> !cmd_is_write
  );

  a_rdy_not_active : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && frame_active)
  );

  // Fixed frame latency set by the SCLK divider
  a_frame_latency : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cs_n) |-> $past(accept, FRAME_LATENCY)
  );

endmodule

/* source/spi_master.sv */
module spi_master
  import spi_pkg::*;
#(
  parameter int SCLK_DIV = 2  // clk cycles per SCLK half period
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic                  accept;
  logic                  frame_active;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  bit_count_done;
  logic [READ_WIDTH-1:0] rx_byte;
  logic                  cmd_is_write;

  spi_sclk_gen #(
    .SCLK_DIV(SCLK_DIV)
  ) u_sclk_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_active(frame_active),
    .sclk        (sclk),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall)
  );

  spi_tx_shift u_tx_shift (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept      (accept),
    .cmd_in      (cmd_in),
    .sclk_fall   (sclk_fall),
    .mosi        (mosi),
    .cmd_is_write(cmd_is_write)
  );

  spi_rx_shift u_rx_shift (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept        (accept),
    .sclk_rise     (sclk_rise),
    .miso          (miso),
    .rx_byte       (rx_byte),
    .bit_count_done(bit_count_done)
  );

  spi_ctrl #(
    .SCLK_DIV(SCLK_DIV)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .accept        (accept),
    .frame_active  (frame_active),
    .sclk_fall     (sclk_fall),
    .bit_count_done(bit_count_done),
    .rx_byte       (rx_byte),
    .cmd_is_write  (cmd_is_write),
    .cs_n          (cs_n),
    .read_vld      (read_vld),
    .read_data     (read_data)
  );

endmodule

/* source/spi_pkg.sv */
package spi_pkg;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int ADDR_WIDTH = 3;
  localparam int FRAME_BITS = 12;  // SCLK periods per frame

  // Write frame, rw set
  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [READ_WIDTH-1:0] wdata;
  } spi_wr_cmd_t;

  // Read frame, rw clear, low byte is don't care on the wire
  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [READ_WIDTH-1:0] pad;
  } spi_rd_cmd_t;

  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACTIVE = 2'd1,
    DONE   = 2'd2
  } spi_state_t;

endpackage

/* source/spi_rx_shift.sv */
module spi_rx_shift
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  accept,
  input  logic                  sclk_rise,
  input  logic                  miso,
  output logic [READ_WIDTH-1:0] rx_byte,
  output logic                  bit_count_done
);

  logic [3:0]            bit_cnt;
  logic [READ_WIDTH-1:0] rx_q;

  // Rising strobes seen in this frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
    end
    else if (accept)
    begin
      bit_cnt <= '0;
    end
    else if (sclk_rise)
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Only the last 8 bits survive, earlier ones fall off the top
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
    begin
      rx_q <= {rx_q[READ_WIDTH-2:0], miso};
    end
  end

  assign rx_byte        = rx_q;
  assign bit_count_done = sclk_rise && (bit_cnt == 4'(FRAME_BITS - 1));  // 12th sample

  // SCLK generator and controller must stop after exactly one frame of rises
  a_bit_cnt_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    bit_cnt <= 4'(FRAME_BITS)
  );

endmodule

/* source/spi_sclk_gen.sv */
module spi_sclk_gen #(
  parameter int SCLK_DIV = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic frame_active,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  // At least one counter bit, even for SCLK_DIV of 1
  localparam int CNT_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             tick;

  // Last clk cycle of a half period
  assign tick = frame_active && (half_cnt == CNT_W'(SCLK_DIV - 1));

  // Strobes mark the clk edge at which sclk toggles
  assign sclk_rise = tick && !sclk;
  assign sclk_fall = tick && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
    end
    else if (!frame_active)
    begin
      half_cnt <= '0;  // Park between frames
      sclk     <= 1'b0;
    end
    else if (tick)
    begin
      half_cnt <= '0;
      sclk     <= ~sclk;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Frame end from the controller must only come with sclk already back low
  a_sclk_idle_low : assert property (
    @(posedge clk) disable iff (!rst_n)
    !frame_active |-> !sclk
  );

endmodule

/* source/spi_tx_shift.sv */
module spi_tx_shift
  import spi_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     accept,
  input  spi_cmd_t cmd_in,
  input  logic     sclk_fall,
  output logic     mosi,
  output logic     cmd_is_write
);

  spi_cmd_t cmd_q;
  logic     rw_q;

  // Command shift register, MSB first
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_q <= '0;  // Keeps mosi low out of reset
    end
    else if (accept)
    begin
      cmd_q <= cmd_in;
    end
    else if (sclk_fall)
    begin
      cmd_q <= spi_cmd_t'({cmd_q[CMD_WIDTH-2:0], 1'b0});
    end
  end

  // The rw bit gets shifted away, so hold a copy for the whole frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rw_q <= 1'b0;
    end
    else if (accept)
    begin
      rw_q <= cmd_in.wr.rw;
    end
  end

  assign mosi         = cmd_q[CMD_WIDTH-1];
  assign cmd_is_write = rw_q;

endmodule
